/* array_ctl.f */
src/array_pkg.sv
src/ctl_ram_if.sv
src/ctl_ram.sv
src/array_sequencer.sv
src/channel_driver.sv
src/drive_output.sv
src/array_top.sv
verif/array_tb.sv

/* src/array_pkg.sv */
// shared widths, register map and control bits for the transducer array, referenced by scoped name
package array_pkg;

        localparam int DATA_W    = 16;
        localparam int ADDR_W    = 6;
        localparam int CNT_W     = 12;
        localparam int RAM_DEPTH = 1 << ADDR_W;   // 64 words

        typedef logic [DATA_W-1:0] data_t;   // one register word
        typedef logic [ADDR_W-1:0] addr_t;   // register word address
        typedef logic [CNT_W-1:0]  cnt_t;    // period, duty or phase in CLK ticks

        localparam int NUM_CH = 8;

        // register map
        localparam addr_t ADDR_VERSION    = 6'd0;
        localparam addr_t ADDR_CTL        = 6'd1;
        localparam addr_t ADDR_PERIOD     = 6'd2;
        localparam addr_t ADDR_DUTY_BASE  = 6'd16;   // one word per channel
        localparam addr_t ADDR_PHASE_BASE = 6'd32;   // one word per channel

        localparam data_t VERSION_WORD = 16'h0a31;

        // control word bits
        localparam int CTL_SYNC_BIT      = 0;   // host sets, sequencer clears after the load
        localparam int CTL_OUT_EN_BIT    = 1;
        localparam int CTL_FORCE_FAN_BIT = 2;

        // sequencer states
        // names give what the state captures first and what it issues second
        typedef enum logic [2:0] {
                ST_WR_VER,       // version write in flight
                ST_REQ_PERIOD,   // first period request of a pass
                ST_RD_CTL,       // capture control word, reissue its address
                ST_RD_PERIOD,    // capture period, reissue its address
                ST_SYNC_REQ,     // second duty/phase request, nothing to capture yet
                ST_SYNC_RD,      // capture one duty/phase word per cycle
                ST_SYNC_LOAD,    // shadows to channels, start sync bit clear
                ST_SYNC_CLR      // write back in flight, restart polling
        } seq_state_t;

endpackage

/* src/array_sequencer.sv */
// moves register RAM contents into drive settings; polls control and period, runs syncs
`timescale 1ns/100ps

module array_sequencer (
        input  logic            CLK,
        input  logic            arst_n,
        ctl_ram_if.seq          ram,
        output logic            load,
        output array_pkg::cnt_t period,
        output array_pkg::cnt_t duty [array_pkg::NUM_CH],
        output array_pkg::cnt_t phase [array_pkg::NUM_CH],
        output logic            sync_set,
        output logic            out_en,
        output logic            force_fan
);

        array_pkg::seq_state_t state;

        array_pkg::data_t ctl_reg;              // control word as last polled
        array_pkg::cnt_t  duty_sh [array_pkg::NUM_CH];
        array_pkg::cnt_t  phase_sh [array_pkg::NUM_CH];
        logic [4:0]       req_idx;              // next duty/phase word to request, 0..16
        logic [3:0]       rd_idx;               // duty/phase word being captured

        // word k of the sync block, duties first then phases
        function automatic array_pkg::addr_t sync_addr(input logic [3:0] k);
                array_pkg::addr_t base;
                base = k[3] ? array_pkg::ADDR_PHASE_BASE : array_pkg::ADDR_DUTY_BASE;
                return base + array_pkg::addr_t'(k[2:0]);
        endfunction

        assign out_en    = ctl_reg[array_pkg::CTL_OUT_EN_BIT];
        assign force_fan = ctl_reg[array_pkg::CTL_FORCE_FAN_BIT];

        // read data arrives two states after the address is issued
        always_ff @(posedge CLK or negedge arst_n) begin
                if (!arst_n) begin
                        state     <= array_pkg::ST_WR_VER;
                        ram.we    <= 1'b1;     // version write lands on the first edge
                        ram.addr  <= array_pkg::ADDR_VERSION;
                        ram.wdata <= array_pkg::VERSION_WORD;
                        ctl_reg   <= '0;
                        period    <= '0;
                        duty      <= '{default: '0};
                        phase     <= '{default: '0};
                        load      <= 1'b0;
                        sync_set  <= 1'b0;
                        req_idx   <= '0;
                        rd_idx    <= '0;
                end else begin
                        case (state)
                        array_pkg::ST_WR_VER: begin
                                ram.we   <= 1'b0;
                                ram.addr <= array_pkg::ADDR_CTL;
                                state    <= array_pkg::ST_REQ_PERIOD;
                        end
                        array_pkg::ST_REQ_PERIOD: begin
                                ram.addr <= array_pkg::ADDR_PERIOD;
                                state    <= array_pkg::ST_RD_CTL;
                        end
                        array_pkg::ST_RD_CTL: begin
                                ctl_reg <= ram.rdata;
                                if (ram.rdata[array_pkg::CTL_SYNC_BIT]) begin
                                        ram.addr <= sync_addr(4'd0);
                                        req_idx  <= 5'd1;
                                        rd_idx   <= '0;
                                        state    <= array_pkg::ST_SYNC_REQ;
                                end else begin
                                        ram.addr <= array_pkg::ADDR_CTL;   // for the next pass
                                        state    <= array_pkg::ST_RD_PERIOD;
                                end
                        end
                        array_pkg::ST_RD_PERIOD: begin
                                period   <= ram.rdata[array_pkg::CNT_W-1:0];
                                ram.addr <= array_pkg::ADDR_PERIOD;
                                state    <= array_pkg::ST_RD_CTL;
                        end
                        array_pkg::ST_SYNC_REQ: begin
                                ram.addr <= sync_addr(req_idx[3:0]);
                                req_idx  <= req_idx + 5'd1;
                                state    <= array_pkg::ST_SYNC_RD;
                        end
                        array_pkg::ST_SYNC_RD: begin
                                // bit 3 picks the phase block, low bits the channel
                                if (rd_idx[3])
                                        phase_sh[rd_idx[2:0]] <= ram.rdata[array_pkg::CNT_W-1:0];
                                else
                                        duty_sh[rd_idx[2:0]] <= ram.rdata[array_pkg::CNT_W-1:0];
                                if (req_idx != 5'd16) begin
                                        ram.addr <= sync_addr(req_idx[3:0]);
                                        req_idx  <= req_idx + 5'd1;
                                end
                                if (rd_idx == 4'd15)
                                        state <= array_pkg::ST_SYNC_LOAD;
                                else
                                        rd_idx <= rd_idx + 4'd1;
                        end
                        array_pkg::ST_SYNC_LOAD: begin
                                duty      <= duty_sh;
                                phase     <= phase_sh;
                                load      <= 1'b1;
                                sync_set  <= 1'b1;
                                ram.we    <= 1'b1;
                                ram.addr  <= array_pkg::ADDR_CTL;
                                ram.wdata <= ctl_reg &
                                        ~(array_pkg::data_t'(1) << array_pkg::CTL_SYNC_BIT);
                                state     <= array_pkg::ST_SYNC_CLR;
                        end
                        array_pkg::ST_SYNC_CLR: begin
                                load     <= 1'b0;
                                sync_set <= 1'b0;
                                ram.we   <= 1'b0;
                                ram.addr <= array_pkg::ADDR_CTL;   // re-read sees the cleared bit
                                state    <= array_pkg::ST_REQ_PERIOD;
                        end
                        default: begin
                                ram.we <= 1'b0;
                                state  <= array_pkg::ST_WR_VER;
                        end
                        endcase
                end
        end

        a_load_sync: assert property (@(posedge CLK) disable iff (!arst_n)
                load == sync_set)
                else $error("load and sync_set differ");

endmodule

/* src/array_top.sv */
// top level of the transducer array controller; host bus in, drive lines out
`timescale 1ns/100ps

module array_top (
        input  logic                         CLK,
        input  logic                         arst_n,
        input  logic                         cpu_en,
        input  logic                         cpu_we,
        input  array_pkg::addr_t             cpu_addr,
        input  array_pkg::data_t             cpu_wdata,
        output array_pkg::data_t             cpu_rdata,
        output logic [array_pkg::NUM_CH-1:0] drive,
        output logic                         sync_set,
        output logic                         force_fan
);

        ctl_ram_if ram_bus ();

        logic                         load;
        logic                         out_en;
        array_pkg::cnt_t              period;
        array_pkg::cnt_t              duty [array_pkg::NUM_CH];
        array_pkg::cnt_t              phase [array_pkg::NUM_CH];
        logic [array_pkg::NUM_CH-1:0] pulse;

        ctl_ram u_ram (
                .CLK       (CLK),
                .cpu_en    (cpu_en),
                .cpu_we    (cpu_we),
                .cpu_addr  (cpu_addr),
                .cpu_wdata (cpu_wdata),
                .cpu_rdata (cpu_rdata),
                .port      (ram_bus.mem)
        );

        array_sequencer u_seq (
                .CLK       (CLK),
                .arst_n    (arst_n),
                .ram       (ram_bus.seq),
                .load      (load),
                .period    (period),
                .duty      (duty),
                .phase     (phase),
                .sync_set  (sync_set),
                .out_en    (out_en),
                .force_fan (force_fan)
        );

        // all channels share period and load
        for (genvar i = 0; i < array_pkg::NUM_CH; i++) begin : g_ch
                channel_driver u_ch (
                        .CLK    (CLK),
                        .arst_n (arst_n),
                        .load   (load),
                        .period (period),
                        .duty   (duty[i]),
                        .phase  (phase[i]),
                        .pulse  (pulse[i])
                );
        end

        drive_output u_out (
                .CLK    (CLK),
                .arst_n (arst_n),
                .out_en (out_en),
                .pulse  (pulse),
                .drive  (drive)
        );

endmodule

/* src/channel_driver.sv */
// one transducer channel; free-running period counter with pulse-width output
`timescale 1ns/100ps

module channel_driver (
        input  logic            CLK,
        input  logic            arst_n,
        input  logic            load,
        input  array_pkg::cnt_t period,
        input  array_pkg::cnt_t duty,
        input  array_pkg::cnt_t phase,
        output logic            pulse
);

        array_pkg::cnt_t cnt;
        logic            at_end;

        // also catches a count left above a period that just shrank
        assign at_end = (cnt >= period - array_pkg::cnt_t'(1));

        always_ff @(posedge CLK or negedge arst_n) begin
                if (!arst_n) begin
                        cnt <= '0;
                end else if (period == '0) begin
                        cnt <= '0;                  // channel idle
                end else if (load) begin
                        cnt <= phase % period;      // align all channels on sync
                end else if (at_end) begin
                        cnt <= '0;
                end else begin
                        cnt <= cnt + array_pkg::cnt_t'(1);
                end
        end

        assign pulse = (period != '0) && (cnt < duty);   // raw, registered downstream

endmodule

/* src/ctl_ram.sv */
// dual-port register RAM shared by the host bus and the array sequencer, both on CLK
`timescale 1ns/100ps

module ctl_ram (
        input  logic             CLK,
        input  logic             cpu_en,
        input  logic             cpu_we,
        input  array_pkg::addr_t cpu_addr,
        input  array_pkg::data_t cpu_wdata,
        output array_pkg::data_t cpu_rdata,
        ctl_ram_if.mem           port
);

        array_pkg::data_t mem [array_pkg::RAM_DEPTH];

        logic host_wr;
        logic seq_wr;

        assign host_wr = cpu_en && cpu_we;
        // host owns the word when both ports write it in the same cycle
        assign seq_wr  = port.we && !(host_wr && (cpu_addr == port.addr));

        always_ff @(posedge CLK) begin
                if (host_wr)
                        mem[cpu_addr] <= cpu_wdata;
                if (seq_wr)
                        mem[port.addr] <= port.wdata;
        end

        // host read data only moves on an access, so it holds between strobes
        always_ff @(posedge CLK) begin
                if (cpu_en)
                        cpu_rdata <= mem[cpu_addr];
        end

        always_ff @(posedge CLK) begin
                port.rdata <= mem[port.addr];   // read-before-write on a collision
        end

        a_cpu_addr: assert property (@(posedge CLK)
                cpu_en |-> !$isunknown(cpu_addr) && (int'(cpu_addr) < array_pkg::RAM_DEPTH))
                else $error("host address out of range");

        a_seq_addr: assert property (@(posedge CLK)
                port.we |-> !$isunknown(port.addr) && (int'(port.addr) < array_pkg::RAM_DEPTH))
                else $error("sequencer write address out of range");

endmodule

/* src/ctl_ram_if.sv */
// sequencer side of the register RAM; the sequencer drives the seq modport, the RAM takes mem
`timescale 1ns/100ps

interface ctl_ram_if;

        array_pkg::addr_t addr;
        logic             we;
        array_pkg::data_t wdata;
        array_pkg::data_t rdata;   // one cycle after addr

        modport seq (
                output addr,
                output we,
                output wdata,
                input  rdata
        );

        modport mem (
                input  addr,
                input  we,
                input  wdata,
                output rdata
        );

endinterface

/* src/drive_output.sv */
// output stage; gates every raw channel pulse with the enable bit and registers it
`timescale 1ns/100ps

module drive_output (
        input  logic                       CLK,
        input  logic                       arst_n,
        input  logic                       out_en,
        input  logic [array_pkg::NUM_CH-1:0] pulse,
        output logic [array_pkg::NUM_CH-1:0] drive
);

        always_ff @(posedge CLK or negedge arst_n) begin
                if (!arst_n)
                        drive <= '0;
                else if (out_en)
                        drive <= pulse;
                else
                        drive <= '0;   // transducers idle
        end

        a_drive_off: assert property (@(posedge CLK) disable iff (!arst_n)
                !out_en |=> (drive == '0))
                else $error("drive active after out_en cleared");

endmodule

/* verif/array_tb.sv */
// testbench for array_top; random host traffic and syncs, drive lines checked against a channel model
`timescale 1ns/100ps

module array_tb;

        localparam int NUM_SYNC  = 10;
        localparam int NUM_TESTS = NUM_SYNC + 2;   // version read and read-back run first
        localparam int SYNC_WAIT = 64;             // cycles allowed for one sync sequence

        logic                         CLK;
        logic                         arst_n;
        logic                         cpu_en;
        logic                         cpu_we;
        array_pkg::addr_t             cpu_addr;
        array_pkg::data_t             cpu_wdata;
        array_pkg::data_t             cpu_rdata;
        logic [array_pkg::NUM_CH-1:0] drive;
        logic                         sync_set;
        logic                         force_fan;

        integer seed;

        array_pkg::data_t             shadow [array_pkg::RAM_DEPTH];   // host view of the RAM
        array_pkg::cnt_t              m_per;
        array_pkg::cnt_t              m_duty [array_pkg::NUM_CH];
        array_pkg::cnt_t              m_cnt [array_pkg::NUM_CH];
        logic                         m_out_en;
        logic                         sync_q;      // sync_set taken at the falling edge
        logic [array_pkg::NUM_CH-1:0] pred;        // expected drive after the edge
        logic                         check_en;

        array_top UUT (
                .CLK       (CLK),
                .arst_n    (arst_n),
                .cpu_en    (cpu_en),
                .cpu_we    (cpu_we),
                .cpu_addr  (cpu_addr),
                .cpu_wdata (cpu_wdata),
                .cpu_rdata (cpu_rdata),
                .drive     (drive),
                .sync_set  (sync_set),
                .force_fan (force_fan)
        );

        always #2 CLK = ~CLK;

        task automatic report_fail(input string what);
                $display("%s", what);
                $display("Errors found");
                $fatal(1, "simulation stopped at the first error");
        endtask

        task automatic check_word(input string name, input array_pkg::data_t got,
                                  input array_pkg::data_t exp);
                if (got !== exp)
                        report_fail($sformatf("FAIL %s got %h expected %h", name, got, exp));
        endtask

        task automatic check_drive(input string name, input logic [array_pkg::NUM_CH-1:0] got,
                                   input logic [array_pkg::NUM_CH-1:0] exp);
                if (got !== exp)
                        report_fail($sformatf("FAIL %s got %h expected %h", name, got, exp));
        endtask

        task automatic check_bit(input string name, input logic got, input logic exp);
                if (got !== exp)
                        report_fail($sformatf("FAIL %s got %h expected %h", name, got, exp));
        endtask

        // counter set on sync, then counts 0 .. period-1
        function automatic array_pkg::cnt_t load_count(input array_pkg::cnt_t ph,
                                                       input array_pkg::cnt_t per);
                if (per == '0)
                        return '0;
                return ph % per;
        endfunction

        function automatic array_pkg::cnt_t next_count(input array_pkg::cnt_t c,
                                                       input array_pkg::cnt_t per);
                if (per == '0 || c == per - array_pkg::cnt_t'(1))
                        return '0;
                return c + array_pkg::cnt_t'(1);
        endfunction

        function automatic logic [array_pkg::NUM_CH-1:0] model_pulse();
                logic [array_pkg::NUM_CH-1:0] p;
                for (int i = 0; i < array_pkg::NUM_CH; i++)
                        p[i] = (m_per != '0) && (m_cnt[i] < m_duty[i]);
                return p;
        endfunction

        always @(negedge CLK) sync_q <= sync_set;

        // channel model, settings copied from the shadow RAM on the sync strobe
        always @(posedge CLK) begin
                if (!arst_n) begin
                        m_per    <= '0;
                        m_duty   <= '{default: '0};
                        m_cnt    <= '{default: '0};
                        m_out_en <= 1'b0;
                        pred     <= '0;
                end else begin
                        pred <= m_out_en ? model_pulse() : '0;   // registered output stage
                        if (sync_q) begin
                                m_per    <= shadow[array_pkg::ADDR_PERIOD][array_pkg::CNT_W-1:0];
                                m_out_en <= shadow[array_pkg::ADDR_CTL][array_pkg::CTL_OUT_EN_BIT];
                                for (int i = 0; i < array_pkg::NUM_CH; i++) begin
                                        m_duty[i] <= shadow[array_pkg::ADDR_DUTY_BASE + i]
                                                           [array_pkg::CNT_W-1:0];
                                        m_cnt[i]  <= load_count(
                                                shadow[array_pkg::ADDR_PHASE_BASE + i]
                                                      [array_pkg::CNT_W-1:0],
                                                shadow[array_pkg::ADDR_PERIOD][array_pkg::CNT_W-1:0]);
                                end
                        end else begin
                                for (int i = 0; i < array_pkg::NUM_CH; i++)
                                        m_cnt[i] <= next_count(m_cnt[i], m_per);
                        end
                end
        end

        always @(negedge CLK) begin
                if (check_en)
                        check_drive("drive", drive, pred);
        end

        // all stimulus tasks start and end 1 ns after a rising edge
        task automatic wait_cycles(input int n);
                repeat (n) begin
                        @(posedge CLK);
                        #1;
                end
        endtask

        task automatic host_write(input array_pkg::addr_t a, input array_pkg::data_t d);
                cpu_en    = 1'b1;
                cpu_we    = 1'b1;
                cpu_addr  = a;
                cpu_wdata = d;
                wait_cycles(1);
                cpu_en    = 1'b0;
                cpu_we    = 1'b0;
                shadow[a] = d;
        endtask

        task automatic host_read(input array_pkg::addr_t a, output array_pkg::data_t d);
                cpu_en   = 1'b1;
                cpu_we   = 1'b0;
                cpu_addr = a;
                wait_cycles(1);
                cpu_en   = 1'b0;
                @(negedge CLK);
                d = cpu_rdata;
                wait_cycles(1);
        endtask

        task automatic wait_sync();
                bit seen;
                seen = 1'b0;
                for (int n = 0; n < SYNC_WAIT && !seen; n++) begin
                        @(negedge CLK);
                        if (sync_set)
                                seen = 1'b1;
                end
                if (!seen)
                        report_fail("sync_set did not pulse after the sync bit was set");
                wait_cycles(1);
        endtask

        task automatic run_readback();
                logic [31:0]      r;
                array_pkg::addr_t a;
                array_pkg::data_t got;
                for (int n = 0; n < 32; n++) begin
                        r = $random(seed);
                        a = array_pkg::addr_t'(2 + r[15:0] % 62);   // skip version and control
                        host_write(a, r[31:16]);
                        host_read(a, got);
                        check_word("cpu_rdata", got, shadow[a]);
                end
        endtask

        task automatic run_sync(input int t);
                logic [31:0]      r;
                array_pkg::cnt_t  per;
                array_pkg::data_t got;
                array_pkg::addr_t a;
                logic             en;
                check_en = 1'b0;   // period may move before the sync
                r   = $random(seed);
                per = array_pkg::cnt_t'(r[15:0] % 50);
                host_write(array_pkg::ADDR_PERIOD, {r[31:28], per});
                for (int i = 0; i < array_pkg::NUM_CH; i++) begin
                        r = $random(seed);
                        host_write(array_pkg::addr_t'(array_pkg::ADDR_DUTY_BASE + i),
                                   {r[31:28], array_pkg::cnt_t'(r[15:0] % (per + 4))});
                        r = $random(seed);
                        host_write(array_pkg::addr_t'(array_pkg::ADDR_PHASE_BASE + i), r[31:16]);
                end
                for (int i = 0; i < array_pkg::NUM_CH; i++) begin
                        a = array_pkg::addr_t'(array_pkg::ADDR_DUTY_BASE + i);
                        host_read(a, got);
                        check_word("duty word", got, shadow[a]);
                        a = array_pkg::addr_t'(array_pkg::ADDR_PHASE_BASE + i);
                        host_read(a, got);
                        check_word("phase word", got, shadow[a]);
                end
                wait_cycles(8);    // let the polling loop pick up the period
                r  = $random(seed);
                en = (t % 3) != 2;
                host_write(array_pkg::ADDR_CTL, {r[15:3], r[20], en, 1'b1});
                wait_sync();
                shadow[array_pkg::ADDR_CTL][array_pkg::CTL_SYNC_BIT] = 1'b0;
                wait_cycles(1);
                check_en = 1'b1;
                wait_cycles(4);
                host_read(array_pkg::ADDR_CTL, got);
                check_word("ctl word", got, shadow[array_pkg::ADDR_CTL]);
                check_bit("force_fan", force_fan,
                          shadow[array_pkg::ADDR_CTL][array_pkg::CTL_FORCE_FAN_BIT]);
                if (!en)
                        check_drive("drive", drive, '0);
                wait_cycles(60);
        endtask

        initial begin
                #(NUM_TESTS * 400 * 4);
                report_fail("test timed out before all checks completed");
        end

        initial begin
                array_pkg::data_t got;
                CLK       = 1'b0;
                arst_n    = 1'b0;
                cpu_en    = 1'b0;
                cpu_we    = 1'b0;
                cpu_addr  = '0;
                cpu_wdata = '0;
                check_en  = 1'b0;
                seed      = 32'hb409;
                repeat (10) @(posedge CLK);
                #1;
                arst_n = 1'b1;
                shadow[array_pkg::ADDR_VERSION] = array_pkg::VERSION_WORD;
                wait_cycles(2);
                host_read(array_pkg::ADDR_VERSION, got);
                check_word("version word", got, array_pkg::VERSION_WORD);
                host_write(array_pkg::ADDR_CTL, '0);
                run_readback();
                for (int t = 0; t < NUM_SYNC; t++)
                        run_sync(t);
                check_en = 1'b0;
                $display("No errors");
                $finish;
        end

endmodule
